// File: list.f
+incdir+logic
logic/soc_misc_pkg.sv
logic/bus_decode.sv
logic/misc_regs.sv
logic/flash_select_seq.sv
logic/soc_misc_top.sv
verif/soc_misc_tb.sv

// File: verif/soc_misc_tb.sv
// misc register block testbench
`timescale 1ns/1ps
`include "soc_misc_config.svh"

module soc_misc_tb import soc_misc_pkg::*; ();

	// about 80 accesses of 4 cycles each and three select waits fit well inside
	localparam int MAX_CYCLES = 3000;

	logic clk48m = 1'b0;
	logic rst;
	logic bus_valid;
	logic [31:0] bus_addr;
	logic [31:0] bus_wdata;
	logic [3:0] bus_wstrb;
	logic [31:0] bus_rdata;
	logic bus_ready;
	logic bus_error_irq;
	logic [`BTN_W-1:0] btn;
	logic [`LED_W-1:0] led;
	logic [`GENIO_W-1:0] genio_in, genio_out, genio_oe;
	logic [`PMOD_W-1:0] pmod_in, pmod_out, pmod_oe;
	logic [`SAO_W-1:0] sao1_in, sao1_out, sao1_oe;
	logic [`SAO_W-1:0] sao2_in, sao2_out, sao2_oe;
	logic fsel_d, fsel_c, programn;

	// reference model registers
	logic [`LED_W-1:0] m_led;
	logic [`GENIO_W-1:0] m_genio_out, m_genio_oe;
	logic [`PMOD_W-1:0] m_pmod_out, m_pmod_oe;
	logic [`SAO_W-1:0] m_sao1_out, m_sao1_oe, m_sao2_out, m_sao2_oe;
	logic m_fsel_d, m_reload, m_prog_low;

	// access in flight and select sequence tracking
	logic pend, seq_on, exp_ready, exp_irq, exp_fsel_c;
	logic seen_rst = 1'b0;
	logic [31:0] a_addr, a_wdata, exp_rdata;
	logic [3:0] a_wstrb;
	int age, seq_age;
	int cycles = 0;
	int value_errors = 0;
	int other_errors = 0;

	soc_misc_top dut0 (.*);

	always #2 clk48m = ~clk48m;

	task automatic check_val(input string name, input logic [31:0] exp_v,
		input logic [31:0] got_v);
		assert (got_v === exp_v) else begin
			value_errors++;
			$display("CHECK FAILED at %0t: %s expected %h, got %h",
				$time, name, exp_v, got_v);
		end
	endtask

	task automatic model_reset;
		m_led = '0;
		m_genio_out = '0;
		m_genio_oe = '0;
		m_pmod_out = '0;
		m_pmod_oe = '0;
		m_sao1_out = '0;
		m_sao1_oe = '0;
		m_sao2_out = '0;
		m_sao2_oe = '0;
		m_fsel_d = 1'b0;
		m_reload = 1'b0;
		m_prog_low = 1'b0;
		pend = 1'b0;
		age = 0;
		seq_on = 1'b0;
		seq_age = 0;
	endtask

	function automatic logic [31:0] model_read(input logic [4:0] idx);
		gpext_word_u w;
		w = '0;
		case (idx)
			`REG_LED: return {{(32 - `LED_W){1'b0}}, m_led};
			`REG_BTN: return {{(32 - `BTN_W){1'b0}}, ~btn};
			`REG_SOC_VER: return `SOC_VERSION;
			`REG_FLASH_SEL: return {31'h0, m_fsel_d};
			`REG_GENIO_IN: return {{(32 - `GENIO_W){1'b0}}, genio_in};
			`REG_GENIO_OUT: return {{(32 - `GENIO_W){1'b0}}, m_genio_out};
			`REG_GENIO_OE: return {{(32 - `GENIO_W){1'b0}}, m_genio_oe};
			`REG_GPEXT_IN: begin
				w.f.pmod = pmod_in;
				w.f.sao1 = sao1_in;
				w.f.sao2 = sao2_in;
			end
			`REG_GPEXT_OUT: begin
				w.f.pmod = m_pmod_out;
				w.f.sao1 = m_sao1_out;
				w.f.sao2 = m_sao2_out;
			end
			`REG_GPEXT_OE: begin
				w.f.pmod = m_pmod_oe;
				w.f.sao1 = m_sao1_oe;
				w.f.sao2 = m_sao2_oe;
			end
			default: w = '0;
		endcase
		return w.raw;
	endfunction

	task automatic model_write(input logic [4:0] idx, input logic [31:0] d);
		gpext_word_u w;
		w.raw = d;
		case (idx)
			`REG_LED: m_led = d[`LED_W-1:0];
			`REG_FLASH_SEL: begin
				m_fsel_d = d[0];
				seq_on = 1'b1;
				seq_age = 0;
				if (d[31:8] == `RELOAD_MAGIC) begin
					m_reload = 1'b1;
				end
			end
			`REG_GENIO_OUT: m_genio_out = d[`GENIO_W-1:0];
			`REG_GENIO_OE: m_genio_oe = d[`GENIO_W-1:0];
			`REG_GENIO_W2S: m_genio_out = m_genio_out | d[`GENIO_W-1:0];
			`REG_GENIO_W2C: m_genio_out = m_genio_out & ~d[`GENIO_W-1:0];
			`REG_GPEXT_OUT: begin
				m_pmod_out = w.f.pmod;
				m_sao1_out = w.f.sao1;
				m_sao2_out = w.f.sao2;
			end
			`REG_GPEXT_OE: begin
				m_pmod_oe = w.f.pmod;
				m_sao1_oe = w.f.sao1;
				m_sao2_oe = w.f.sao2;
			end
			`REG_GPEXT_W2S: begin
				m_pmod_out = m_pmod_out | w.f.pmod;
				m_sao1_out = m_sao1_out | w.f.sao1;
				m_sao2_out = m_sao2_out | w.f.sao2;
			end
			`REG_GPEXT_W2C: begin
				m_pmod_out = m_pmod_out & ~w.f.pmod;
				m_sao1_out = m_sao1_out & ~w.f.sao1;
				m_sao2_out = m_sao2_out & ~w.f.sao2;
			end
			default: begin
				// read-only index needs no model
			end
		endcase
	endtask

	task automatic check_pins;
		check_val("led", m_led, led);
		check_val("genio_out", m_genio_out, genio_out);
		check_val("genio_oe", m_genio_oe, genio_oe);
		check_val("pmod_out", m_pmod_out, pmod_out);
		check_val("pmod_oe", m_pmod_oe, pmod_oe);
		check_val("sao1_out", m_sao1_out, sao1_out);
		check_val("sao1_oe", m_sao1_oe, sao1_oe);
		check_val("sao2_out", m_sao2_out, sao2_out);
		check_val("sao2_oe", m_sao2_oe, sao2_oe);
		check_val("fsel_d", m_fsel_d, fsel_d);
		check_val("fsel_c", exp_fsel_c, fsel_c);
		check_val("programn", !m_prog_low, programn);
	endtask

	// checker sampling the settled outputs at every rising edge
	always @(posedge clk48m) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			other_errors++;
			$display("timeout after %0d cycles without the test sequence finishing",
				MAX_CYCLES);
			$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
			$display("tests failed");
			$finish;
		end else if (rst) begin
			model_reset();
			exp_fsel_c = 1'b0;
			if (seen_rst) begin
				check_val("bus_ready", 1'b0, bus_ready);
				check_val("bus_error_irq", 1'b0, bus_error_irq);
				check_pins();
			end
			seen_rst = 1'b1;
		end else begin
			// cycle R is sampled with seq_age 0
			if (seq_on) begin
				seq_age++;
			end
			if (seq_on && seq_age == 8 && m_reload) begin
				m_prog_low = 1'b1;
			end
			exp_fsel_c = seq_on && seq_age >= 3 && seq_age <= 5;
			exp_ready = pend && age == 1;
			exp_irq = exp_ready && a_addr[31:28] != `REGION_MISC;
			check_val("bus_ready", exp_ready, bus_ready);
			check_val("bus_error_irq", exp_irq, bus_error_irq);
			if (exp_ready) begin
				if (exp_irq || !a_wstrb[0]) begin
					check_val("bus_rdata", exp_rdata, bus_rdata);
				end
				if (!exp_irq && a_wstrb[0]) begin
					model_write(a_addr[6:2], a_wdata);
				end
				pend = 1'b0;
			end else if (pend) begin
				age = 1;
				if (a_addr[31:28] == `REGION_MISC) begin
					exp_rdata = model_read(a_addr[6:2]);
				end else begin
					exp_rdata = `BUS_ERROR_WORD;
				end
			end else if (bus_valid) begin
				pend = 1'b1;
				age = 0;
				a_addr = bus_addr;
				a_wdata = bus_wdata;
				a_wstrb = bus_wstrb;
			end
			check_pins();
		end
	end

	function automatic logic [31:0] misc_addr(input logic [4:0] idx);
		return {`REGION_MISC, 21'h0, idx, 2'b00};
	endfunction

	task automatic bus_access(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		@(negedge clk48m);
		bus_valid = 1'b1;
		bus_addr = addr;
		bus_wdata = data;
		bus_wstrb = strb;
		do begin
			@(negedge clk48m);
		end while (!bus_ready);
		bus_valid = 1'b0;
		bus_wstrb = 4'h0;
	endtask

	task automatic write_reg(input logic [4:0] idx, input logic [31:0] data);
		bus_access(misc_addr(idx), data, 4'hF);
	endtask

	task automatic read_reg(input logic [4:0] idx);
		bus_access(misc_addr(idx), 32'h0, 4'h0);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk48m);
	endtask

	initial begin
		int seed;
		logic [31:0] w;
		logic [31:0] d;
		seed = $urandom(71);
		rst = 1'b1;
		bus_valid = 1'b0;
		bus_addr = '0;
		bus_wdata = '0;
		bus_wstrb = '0;
		btn = '0;
		genio_in = '0;
		pmod_in = '0;
		sao1_in = '0;
		sao2_in = '0;
		repeat (10) @(negedge clk48m);
		rst = 1'b0;
		idle_cycles(3);

		// leds, buttons, version and unlisted indexes
		repeat (4) begin
			w = $urandom;
			write_reg(`REG_LED, w);
			read_reg(`REG_LED);
		end
		repeat (3) begin
			w = $urandom;
			btn = w[`BTN_W-1:0];
			read_reg(`REG_BTN);
		end
		read_reg(`REG_SOC_VER);
		read_reg(5'd5);
		read_reg(5'd30);

		// random mix of general I/O out, oe, set and clear writes
		repeat (12) begin
			w = $urandom;
			d = $urandom;
			write_reg(`REG_GENIO_OUT + {3'b000, w[1:0]}, d);
			read_reg(`REG_GENIO_OUT + {4'b0000, w[2]});
		end
		repeat (3) begin
			w = $urandom;
			genio_in = w[`GENIO_W-1:0];
			read_reg(`REG_GENIO_IN);
		end

		// extension port bank
		repeat (12) begin
			w = $urandom;
			d = $urandom;
			write_reg(`REG_GPEXT_OUT + {3'b000, w[1:0]}, d);
			read_reg(`REG_GPEXT_OUT + {4'b0000, w[2]});
		end
		repeat (3) begin
			w = $urandom;
			pmod_in = w[`PMOD_W-1:0];
			sao1_in = w[8 +: `SAO_W];
			sao2_in = w[16 +: `SAO_W];
			read_reg(`REG_GPEXT_IN);
		end

		// accesses outside the misc region with about half of them writes
		repeat (8) begin
			w = $urandom;
			d = $urandom;
			if (w[31:28] == `REGION_MISC) begin
				w[31] = 1'b1;
			end
			bus_access(w, d, w[0] ? 4'hF : 4'h0);
		end
		read_reg(`REG_LED);

		// flash select without the reload word
		d = $urandom;
		if (d[31:8] == `RELOAD_MAGIC) begin
			d[31] = ~d[31];
		end
		d[0] = 1'b1;
		write_reg(`REG_FLASH_SEL, d);
		idle_cycles(12);
		read_reg(`REG_FLASH_SEL);
		d[0] = 1'b0;
		write_reg(`REG_FLASH_SEL, d);
		idle_cycles(12);
		read_reg(`REG_FLASH_SEL);

		// the reload word pulls PROGRAMN low for good
		write_reg(`REG_FLASH_SEL, {`RELOAD_MAGIC, 8'h01});
		idle_cycles(12);
		read_reg(`REG_FLASH_SEL);
		idle_cycles(4);

		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: logic/soc_misc_top.sv
// misc register block top level
`timescale 1ns/1ps
`include "soc_misc_config.svh"

module soc_misc_top import soc_misc_pkg::*; (
	input logic clk48m,
	input logic rst,
	input logic bus_valid,
	input logic [31:0] bus_addr,
	input logic [31:0] bus_wdata,
	input logic [3:0] bus_wstrb,
	output logic [31:0] bus_rdata,
	output logic bus_ready,
	output logic bus_error_irq,
	input logic [`BTN_W-1:0] btn,
	output logic [`LED_W-1:0] led,
	input logic [`GENIO_W-1:0] genio_in,
	output logic [`GENIO_W-1:0] genio_out,
	output logic [`GENIO_W-1:0] genio_oe,
	input logic [`PMOD_W-1:0] pmod_in,
	output logic [`PMOD_W-1:0] pmod_out,
	output logic [`PMOD_W-1:0] pmod_oe,
	input logic [`SAO_W-1:0] sao1_in,
	output logic [`SAO_W-1:0] sao1_out,
	output logic [`SAO_W-1:0] sao1_oe,
	input logic [`SAO_W-1:0] sao2_in,
	output logic [`SAO_W-1:0] sao2_out,
	output logic [`SAO_W-1:0] sao2_oe,
	output logic fsel_d,
	output logic fsel_c,
	output logic programn
);

	// decode to execute
	logic req_valid;
	logic req_is_misc;
	logic [`REG_IDX_W-1:0] req_index;
	logic req_write;
	gpext_word_u req_wdata;

	// execute to sequencer
	logic fsel_strobe;
	logic reload_req;

	bus_decode u_bus_decode (
		.clk48m(clk48m),
		.rst(rst),
		.bus_valid(bus_valid),
		.bus_addr(bus_addr),
		.bus_wdata(bus_wdata),
		.bus_wstrb(bus_wstrb),
		.bus_ready(bus_ready),
		.req_valid(req_valid),
		.req_is_misc(req_is_misc),
		.req_index(req_index),
		.req_write(req_write),
		.req_wdata(req_wdata)
	);

	misc_regs u_misc_regs (
		.clk48m(clk48m),
		.rst(rst),
		.req_valid(req_valid),
		.req_is_misc(req_is_misc),
		.req_index(req_index),
		.req_write(req_write),
		.req_wdata(req_wdata),
		.btn(btn),
		.genio_in(genio_in),
		.pmod_in(pmod_in),
		.sao1_in(sao1_in),
		.sao2_in(sao2_in),
		.bus_rdata(bus_rdata),
		.bus_ready(bus_ready),
		.bus_error_irq(bus_error_irq),
		.led(led),
		.genio_out(genio_out),
		.genio_oe(genio_oe),
		.pmod_out(pmod_out),
		.pmod_oe(pmod_oe),
		.sao1_out(sao1_out),
		.sao1_oe(sao1_oe),
		.sao2_out(sao2_out),
		.sao2_oe(sao2_oe),
		.fsel_d(fsel_d),
		.fsel_strobe(fsel_strobe),
		.reload_req(reload_req)
	);

	flash_select_seq u_flash_select_seq (
		.clk48m(clk48m),
		.rst(rst),
		.fsel_strobe(fsel_strobe),
		.reload_req(reload_req),
		.fsel_c(fsel_c),
		.programn(programn)
	);

endmodule

// File: logic/flash_select_seq.sv
// flash select and reload sequencer
`timescale 1ns/1ps
`include "soc_misc_config.svh"

module flash_select_seq (
	input logic clk48m,
	input logic rst,
	input logic fsel_strobe,
	input logic reload_req,
	output logic fsel_c,
	output logic programn
);

	logic [`FSEL_CNT_W-1:0] fsel_cnt;
	logic fpga_reload;

	// clock the select flip-flop in the middle of the count so fsel_d
	// is settled before the edge and before PROGRAMN is pulled
	assign fsel_c = (fsel_cnt == 3'd5) || (fsel_cnt == 3'd4) || (fsel_cnt == 3'd3);

	// PROGRAMN is active low
	assign programn = ~fpga_reload;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_cnt <= '0;
			fpga_reload <= 1'b0;
		end else begin
			if (fsel_strobe) begin
				fsel_cnt <= `FSEL_DELAY;
			end else if (fsel_cnt != '0) begin
				fsel_cnt <= fsel_cnt - 1'b1;
				// last step of the count, select clock is long done
				if (fsel_cnt == 3'd1 && reload_req) begin
					fpga_reload <= 1'b1;
				end
			end
		end
	end

endmodule

// File: logic/misc_regs.sv
// misc register file and bus response
`timescale 1ns/1ps
`include "soc_misc_config.svh"

module misc_regs import soc_misc_pkg::*; (
	input logic clk48m,
	input logic rst,
	input logic req_valid,
	input logic req_is_misc,
	input logic [`REG_IDX_W-1:0] req_index,
	input logic req_write,
	input gpext_word_u req_wdata,
	input logic [`BTN_W-1:0] btn,
	input logic [`GENIO_W-1:0] genio_in,
	input logic [`PMOD_W-1:0] pmod_in,
	input logic [`SAO_W-1:0] sao1_in,
	input logic [`SAO_W-1:0] sao2_in,
	output logic [31:0] bus_rdata,
	output logic bus_ready,
	output logic bus_error_irq,
	output logic [`LED_W-1:0] led,
	output logic [`GENIO_W-1:0] genio_out,
	output logic [`GENIO_W-1:0] genio_oe,
	output logic [`PMOD_W-1:0] pmod_out,
	output logic [`PMOD_W-1:0] pmod_oe,
	output logic [`SAO_W-1:0] sao1_out,
	output logic [`SAO_W-1:0] sao1_oe,
	output logic [`SAO_W-1:0] sao2_out,
	output logic [`SAO_W-1:0] sao2_oe,
	output logic fsel_d,
	output logic fsel_strobe,
	output logic reload_req
);

	logic do_write;
	logic [31:0] rd_word;
	logic [`GENIO_W-1:0] genio_wdata;

	// extension port banks packed into bus words
	gpext_word_u ext_in;
	gpext_word_u ext_out;
	gpext_word_u ext_oe;

	assign do_write = req_valid && req_is_misc && req_write;
	assign genio_wdata = req_wdata.raw[`GENIO_W-1:0];

	always_comb begin
		ext_in = '0;
		ext_in.f.pmod = pmod_in;
		ext_in.f.sao2 = sao2_in;
		ext_in.f.sao1 = sao1_in;
		ext_out = '0;
		ext_out.f.pmod = pmod_out;
		ext_out.f.sao2 = sao2_out;
		ext_out.f.sao1 = sao1_out;
		ext_oe = '0;
		ext_oe.f.pmod = pmod_oe;
		ext_oe.f.sao2 = sao2_oe;
		ext_oe.f.sao1 = sao1_oe;
	end

	// read mux, anything not listed reads as zero
	always_comb begin
		rd_word = '0;
		case (req_index)
			`REG_LED: rd_word = {{(32 - `LED_W){1'b0}}, led};
			// buttons are active low on the board
			`REG_BTN: rd_word = {{(32 - `BTN_W){1'b0}}, ~btn};
			`REG_SOC_VER: rd_word = `SOC_VERSION;
			`REG_FLASH_SEL: rd_word = {31'h0, fsel_d};
			`REG_GENIO_IN: rd_word = {{(32 - `GENIO_W){1'b0}}, genio_in};
			`REG_GENIO_OUT: rd_word = {{(32 - `GENIO_W){1'b0}}, genio_out};
			`REG_GENIO_OE: rd_word = {{(32 - `GENIO_W){1'b0}}, genio_oe};
			`REG_GPEXT_IN: rd_word = ext_in.raw;
			`REG_GPEXT_OUT: rd_word = ext_out.raw;
			`REG_GPEXT_OE: rd_word = ext_oe.raw;
			default: rd_word = '0;
		endcase
	end

	// handshake, interrupt and register writes
	always_ff @(posedge clk48m) begin
		if (rst) begin
			bus_ready <= 1'b0;
			bus_error_irq <= 1'b0;
			led <= '0;
			genio_out <= '0;
			genio_oe <= '0;
			pmod_out <= '0;
			pmod_oe <= '0;
			sao1_out <= '0;
			sao1_oe <= '0;
			sao2_out <= '0;
			sao2_oe <= '0;
			fsel_d <= 1'b0;
			fsel_strobe <= 1'b0;
			reload_req <= 1'b0;
		end else begin
			bus_ready <= req_valid;
			// unmapped region, no register is touched
			bus_error_irq <= req_valid && !req_is_misc;
			fsel_strobe <= 1'b0;
			if (do_write) begin
				case (req_index)
					`REG_LED: begin
						led <= req_wdata.raw[`LED_W-1:0];
					end
					`REG_FLASH_SEL: begin
						fsel_d <= req_wdata.raw[0];
						fsel_strobe <= 1'b1;
						// sticky until reset, the FPGA reloads anyway
						if (req_wdata.raw[31:8] == `RELOAD_MAGIC) begin
							reload_req <= 1'b1;
						end
					end
					`REG_GENIO_OUT: begin
						genio_out <= genio_wdata;
					end
					`REG_GENIO_OE: begin
						genio_oe <= genio_wdata;
					end
					`REG_GENIO_W2S: begin
						genio_out <= genio_out | genio_wdata;
					end
					`REG_GENIO_W2C: begin
						genio_out <= genio_out & ~genio_wdata;
					end
					`REG_GPEXT_OUT: begin
						pmod_out <= req_wdata.f.pmod;
						sao2_out <= req_wdata.f.sao2;
						sao1_out <= req_wdata.f.sao1;
					end
					`REG_GPEXT_OE: begin
						pmod_oe <= req_wdata.f.pmod;
						sao2_oe <= req_wdata.f.sao2;
						sao1_oe <= req_wdata.f.sao1;
					end
					`REG_GPEXT_W2S: begin
						pmod_out <= pmod_out | req_wdata.f.pmod;
						sao2_out <= sao2_out | req_wdata.f.sao2;
						sao1_out <= sao1_out | req_wdata.f.sao1;
					end
					`REG_GPEXT_W2C: begin
						pmod_out <= pmod_out & ~req_wdata.f.pmod;
						sao2_out <= sao2_out & ~req_wdata.f.sao2;
						sao1_out <= sao1_out & ~req_wdata.f.sao1;
					end
					default: begin
						// read-only or unused index
					end
				endcase
			end
		end
	end

	// response word, sampled once per request
	always_ff @(posedge clk48m) begin
		if (req_valid) begin
			bus_rdata <= req_is_misc ? rd_word : `BUS_ERROR_WORD;
		end
	end

endmodule

// File: logic/bus_decode.sv
// bus request decode stage
`timescale 1ns/1ps
`include "soc_misc_config.svh"

module bus_decode import soc_misc_pkg::*; (
	input logic clk48m,
	input logic rst,
	input logic bus_valid,
	input logic [31:0] bus_addr,
	input logic [31:0] bus_wdata,
	input logic [3:0] bus_wstrb,
	input logic bus_ready,
	output logic req_valid,
	output logic req_is_misc,
	output logic [`REG_IDX_W-1:0] req_index,
	output logic req_write,
	output gpext_word_u req_wdata
);

	// an access is in flight from acceptance until ready is seen
	logic busy;
	logic accept;

	// master holds valid until ready, so only take it once
	assign accept = bus_valid && !busy;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			busy <= 1'b0;
			req_valid <= 1'b0;
		end else begin
			req_valid <= accept;
			if (accept) begin
				busy <= 1'b1;
			end else if (bus_ready) begin
				busy <= 1'b0;
			end
		end
	end

	// request fields, only meaningful alongside req_valid
	always_ff @(posedge clk48m) begin
		if (accept) begin
			req_is_misc <= (bus_addr[31:28] == `REGION_MISC);
			req_index <= bus_addr[6:2];
			// byte lane 0 marks a write, all lanes low is a read
			req_write <= bus_wstrb[0];
			req_wdata.raw <= bus_wdata;
		end
	end

endmodule

// File: logic/soc_misc_pkg.sv
// misc block shared types
`include "soc_misc_config.svh"

package soc_misc_pkg;

	// per-header layout of the extension port registers
	typedef struct packed {
		logic [31-`PMOD_W-16:0] pad_hi;
		logic [`PMOD_W-1:0] pmod;
		logic [7-`SAO_W:0] pad_mid;
		logic [`SAO_W-1:0] sao2;
		logic [7-`SAO_W:0] pad_lo;
		logic [`SAO_W-1:0] sao1;
	} gpext_fields_t;

	// bus word of the extension port, as raw data or as header fields
	typedef union packed {
		logic [31:0] raw;
		gpext_fields_t f;
	} gpext_word_u;

endpackage

// File: logic/soc_misc_config.svh
// misc register block constants
`ifndef SOC_MISC_CONFIG_SVH
`define SOC_MISC_CONFIG_SVH

// top address nibble of the misc region
`define REGION_MISC 4'h2

// register index, taken from address bits 6..2
`define REG_IDX_W 5

`define REG_LED 5'd0
`define REG_BTN 5'd1
`define REG_SOC_VER 5'd2
`define REG_FLASH_SEL 5'd13
`define REG_GENIO_IN 5'd17
`define REG_GENIO_OUT 5'd18
`define REG_GENIO_OE 5'd19
`define REG_GENIO_W2S 5'd20
`define REG_GENIO_W2C 5'd21
`define REG_GPEXT_IN 5'd22
`define REG_GPEXT_OUT 5'd23
`define REG_GPEXT_OE 5'd24
`define REG_GPEXT_W2S 5'd25
`define REG_GPEXT_W2C 5'd26

// pin bank widths
`define LED_W 16
`define BTN_W 8
`define GENIO_W 30
`define PMOD_W 8
`define SAO_W 6

`define SOC_VERSION 32'h0000_0100
`define BUS_ERROR_WORD 32'hDEAD_BEEF

// upper 24 bits of a flash select write that request an FPGA reload
`define RELOAD_MAGIC 24'hD0F1A5

// select sequencer counter
`define FSEL_CNT_W 3
`define FSEL_DELAY 3'd7

`endif
